// ==== source/heapPkg.sv ====
// Array heap shared definitions
// Widths, value types, action and error codes, and the structs that
// travel between the bookkeeper, the element store and the responder
package heapPkg;

  // --------------------------------------------------
  // Geometry
  // --------------------------------------------------
  localparam int ADDRESS_BITS = 2;                  // Bits in an array number
  localparam int INDEX_BITS   = 2;                  // Bits in an element index
  localparam int DATA_BITS    = 12;                 // Bits in one element
  localparam int ARRAYS       = 2 ** ADDRESS_BITS;  // Array slots in the pool
  localparam int ARRAY_LENGTH = 2 ** INDEX_BITS;    // Elements per array

  typedef logic [ADDRESS_BITS-1:0] arrayId_t;       // Array number
  typedef logic [INDEX_BITS-1:0]   elementIndex_t;  // Index within an array
  typedef logic [INDEX_BITS:0]     arraySize_t;     // 0 up to ARRAY_LENGTH
  typedef logic [DATA_BITS-1:0]    element_t;       // One data element

  // --------------------------------------------------
  // Codes
  // --------------------------------------------------
  typedef enum logic [3:0] {
    actIdle  = 4'd0,                                // No command this cycle
    actAlloc = 4'd1,                                // Hand out an array
    actFree  = 4'd2,                                // Return an array
    actWrite = 4'd3,                                // Store at index, may grow
    actRead  = 4'd4,                                // Fetch within bounds
    actSize  = 4'd5,                                // Current length
    actPush  = 4'd6,                                // Append at the end
    actPop   = 4'd7,                                // Remove from the end
    actAdd   = 4'd8                                 // Add in place, new value out
  } heapAction_t;

  typedef enum logic [2:0] {
    errNone         = 3'd0,
    errNotAllocated = 3'd1,                         // Never handed out
    errFreed        = 3'd2,                         // Handed out, since freed
    errOutOfBounds  = 3'd3,                         // Index past the size
    errFull         = 3'd4,                         // Push on a full array
    errEmpty        = 3'd5,                         // Pop on an empty array
    errOutOfMemory  = 3'd6                          // No slot left to allocate
  } heapError_t;

  // --------------------------------------------------
  // Structs
  // --------------------------------------------------
  typedef struct packed {
    heapAction_t   action;
    arrayId_t      array;
    elementIndex_t index;
    element_t      data;
  } heapCommand_t;                                  // 20 bits

  typedef struct packed {
    logic          allowed;                         // Error is errNone
    heapError_t    error;
    elementIndex_t slot;                            // Element the store touches
    element_t      bookValue;                       // Allocated array or size
  } heapVerdict_t;

  typedef struct packed {
    element_t   value;
    heapError_t error;
  } heapResponse_t;                                 // 15 bits

endpackage

// ==== source/heapBookkeeper.sv ====
// Array heap bookkeeper
// Tracks which slots are handed out, the stack of freed slots and the
// size of every array; checks each command and issues the verdict
`timescale 1ns/1ps

module heapBookkeeper import heapPkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  heapCommand_t command,
  output heapVerdict_t verdict
);

  // --------------------------------------------------
  // State
  // --------------------------------------------------
  logic [ARRAYS-1:0]     allocFlags;                // Set while a slot is in use
  logic [ADDRESS_BITS:0] handedOut;                 // Slots ever taken from the pool
  logic [ADDRESS_BITS:0] freeTop;                   // Entries on the free stack
  arrayId_t              freeStack [ARRAYS];        // Freed slots, newest on top
  arraySize_t            sizes [ARRAYS];            // Length of each array

  arraySize_t curSize;                              // Size of the addressed array
  arrayId_t   stackTop;                             // Slot on top of the free stack
  arrayId_t   chosen;                               // Slot an Alloc would take
  logic       stackEmpty;
  logic       poolUsed;                             // Every slot handed out once
  logic       doAlloc;
  logic       doFree;

  assign curSize    = sizes[command.array];
  assign stackEmpty = (freeTop == '0);
  assign poolUsed   = (handedOut == ARRAYS);
  assign stackTop   = arrayId_t'(freeTop - 1'b1);
  assign chosen     = stackEmpty ? arrayId_t'(handedOut) : freeStack[stackTop];  // Reuse first

  // --------------------------------------------------
  // Checks and verdict
  // --------------------------------------------------
  always_comb begin
    verdict.error     = errNone;
    verdict.slot      = command.index;
    verdict.bookValue = element_t'(curSize);        // Size reply by default

    case (command.action)
      actIdle: ;
      actAlloc: begin
        if (stackEmpty && poolUsed)
          verdict.error = errOutOfMemory;
        verdict.bookValue = element_t'(chosen);
      end
      default: begin
        if ({1'b0, command.array} >= handedOut)
          verdict.error = errNotAllocated;
        else if (!allocFlags[command.array])
          verdict.error = errFreed;
        else if ((command.action == actRead || command.action == actAdd) &&
                 arraySize_t'(command.index) >= curSize)
          verdict.error = errOutOfBounds;
        else if (command.action == actPush && curSize == ARRAY_LENGTH)
          verdict.error = errFull;
        else if (command.action == actPop && curSize == '0)
          verdict.error = errEmpty;
      end
    endcase

    if (command.action == actPush)
      verdict.slot = elementIndex_t'(curSize);      // Next free element
    else if (command.action == actPop)
      verdict.slot = elementIndex_t'(curSize - 1'b1);  // Last element

    verdict.allowed = (verdict.error == errNone);
  end

  assign doAlloc = verdict.allowed && command.action == actAlloc;
  assign doFree  = verdict.allowed && command.action == actFree;

  // --------------------------------------------------
  // Updates
  // --------------------------------------------------
  always_ff @(posedge clock, negedge reset) begin
    if (!reset) begin
      allocFlags <= '0;
      handedOut  <= '0;
      freeTop    <= '0;
      for (int i = 0; i < ARRAYS; i++)
        sizes[i] <= '0;
    end else if (doAlloc) begin
      if (stackEmpty)
        handedOut <= handedOut + 1'b1;              // Fresh slot from the pool
      else
        freeTop <= freeTop - 1'b1;                  // Pop the newest freed slot
      allocFlags[chosen] <= 1'b1;
      sizes[chosen]      <= '0;
    end else if (doFree) begin
      allocFlags[command.array] <= 1'b0;
      freeTop                   <= freeTop + 1'b1;
    end else if (verdict.allowed) begin
      case (command.action)
        actWrite:
          if (arraySize_t'(command.index) >= curSize)
            sizes[command.array] <= arraySize_t'(command.index) + 1'b1;  // Grow to cover
        actPush: sizes[command.array] <= curSize + 1'b1;
        actPop:  sizes[command.array] <= curSize - 1'b1;
        default: ;
      endcase
    end
  end

  // Free stack contents
  always_ff @(posedge clock) begin
    if (doFree)
      freeStack[arrayId_t'(freeTop)] <= command.array;
  end

endmodule

// ==== source/elementStore.sv ====
// Array heap element store
// Holds the elements of every array, reads the one the command names
// and writes new values only when the bookkeeper allows it
`timescale 1ns/1ps

module elementStore import heapPkg::*; (
  input  logic         clock,
  input  heapCommand_t command,
  input  heapVerdict_t verdict,
  output element_t     storedValue,
  output element_t     sumValue
);

  // --------------------------------------------------
  // Storage
  // --------------------------------------------------
  element_t memory [ARRAYS][ARRAY_LENGTH];          // Fixed block per array

  logic     writeEnable;
  element_t writeValue;

  // Element before this command takes effect
  assign storedValue = memory[command.array][verdict.slot];
  assign sumValue    = storedValue + command.data;  // Wraps at DATA_BITS

  // --------------------------------------------------
  // Write path
  // --------------------------------------------------
  always_comb begin
    writeEnable = 1'b0;
    writeValue  = command.data;
    case (command.action)
      actWrite,
      actPush: writeEnable = verdict.allowed;
      actAdd: begin
        writeEnable = verdict.allowed;
        writeValue  = sumValue;                     // Add stores the new total
      end
      default: ;
    endcase
  end

  always_ff @(posedge clock) begin
    if (writeEnable)
      memory[command.array][verdict.slot] <= writeValue;
  end

endmodule

// ==== source/heapResponder.sv ====
// Array heap responder
// Picks the reply value for the action and registers it with the error
// code and a one-cycle response strobe
`timescale 1ns/1ps

module heapResponder import heapPkg::*; (
  input  logic          clock,
  input  logic          reset,
  input  heapCommand_t  command,
  input  heapVerdict_t  verdict,
  input  element_t      storedValue,
  input  element_t      sumValue,
  output heapResponse_t response,
  output logic          respValid
);

  element_t replyValue;                             // Value for an allowed command

  always_comb begin
    case (command.action)
      actWrite, actPush: replyValue = command.data;
      actRead, actPop:   replyValue = storedValue;
      actAdd:            replyValue = sumValue;
      actSize, actAlloc: replyValue = verdict.bookValue;
      actFree:           replyValue = element_t'(command.array);
      default:           replyValue = response.value;
    endcase
  end

  // --------------------------------------------------
  // Reply registers
  // --------------------------------------------------
  always_ff @(posedge clock, negedge reset) begin
    if (!reset) begin
      response  <= '0;                              // Zero value, errNone
      respValid <= 1'b0;
    end else begin
      respValid <= (command.action != actIdle);
      if (command.action != actIdle) begin
        response.error <= verdict.error;
        if (verdict.allowed)
          response.value <= replyValue;             // Held on error
      end
    end
  end

endmodule

// ==== source/arrayHeap.sv ====
// Array heap top level
// Fixed pool of short arrays behind one command port; the bookkeeper,
// element store and responder all act on the same command
`timescale 1ns/1ps

module arrayHeap import heapPkg::*; (
  input  logic          clock,
  input  logic          reset,
  input  heapCommand_t  command,
  output heapResponse_t response,
  output logic          respValid
);

  heapVerdict_t verdict;                            // Checks and slot for this command
  element_t     storedValue;                        // Element before the command
  element_t     sumValue;                           // Element plus data

  heapBookkeeper bookkeeper (
    .clock   (clock),
    .reset   (reset),
    .command (command),
    .verdict (verdict)
  );

  elementStore store (
    .clock       (clock),
    .command     (command),
    .verdict     (verdict),
    .storedValue (storedValue),
    .sumValue    (sumValue)
  );

  heapResponder responder (
    .clock       (clock),
    .reset       (reset),
    .command     (command),
    .verdict     (verdict),
    .storedValue (storedValue),
    .sumValue    (sumValue),
    .response    (response),
    .respValid   (respValid)
  );

endmodule

// ==== testbench/arrayHeap_properties.sv ====
// Array heap assertions
// Reply timing after reset and per command, and out-of-memory that
// persists until an array is freed
`timescale 1ns/1ps

module arrayHeap_properties import heapPkg::*; (
  input logic          clock,
  input logic          reset,
  input heapCommand_t  command,
  input heapResponse_t response,
  input logic          respValid
);

  logic exhaustedSeen;                              // Out of memory reported, no Free since
  logic exhausted;

  assign exhausted = exhaustedSeen || (respValid && response.error == errOutOfMemory);

  always_ff @(posedge clock, negedge reset) begin
    if (!reset)
      exhaustedSeen <= 1'b0;
    else if (command.action == actFree)
      exhaustedSeen <= 1'b0;                        // A slot may be back on the stack
    else if (exhausted)
      exhaustedSeen <= 1'b1;
  end

  // --------------------------------------------------
  // Properties
  // --------------------------------------------------
  quietAfterReset: assert property (@(posedge clock) $rose(reset) |-> !respValid)
    else $error("respValid high on the first cycle after reset");

  validFollowsCommand: assert property (@(posedge clock) disable iff (!reset)
      respValid == $past(command.action != actIdle))
    else $error("respValid does not match the command one cycle earlier");

  staysOutOfMemory: assert property (@(posedge clock) disable iff (!reset)
      (exhausted && command.action == actAlloc) |=> response.error == errOutOfMemory)
    else $error("Alloc succeeded after out of memory with no Free between");

endmodule

bind arrayHeap arrayHeap_properties heapChecks (
  .clock     (clock),
  .reset     (reset),
  .command   (command),
  .response  (response),
  .respValid (respValid)
);

// ==== testbench/arrayHeapTb.sv ====
// Array heap testbench
// Directed tests of allocation, bounds, stack use, in-place add and free,
// each command checked against values worked out from the heap rules
`timescale 1ns/1ps

module arrayHeapTb import heapPkg::*; ();

  localparam int CYCLE_LIMIT = 400;                 // Well above the full sequence
  localparam int REPLY_WAIT  = 4;                   // Cycles allowed for one reply

  logic          clock;
  logic          reset;
  heapCommand_t  command;
  heapResponse_t response;
  logic          respValid;

  heapResponse_t lastReply;                         // Response to the latest command
  int unsigned   lcgState;
  int            cycles;
  int            checks;
  int            errors;
  int            testErrors;                        // Errors in the running test

  arrayHeap dut (
    .clock     (clock),
    .reset     (reset),
    .command   (command),
    .response  (response),
    .respValid (respValid)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;                     // 20 ns period
  end

  // Cycle limit for a hung run
  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clock);
      cycles++;
    end
    $display("Run stopped after %0d cycles without finishing the tests", cycles);
    $display("Test failed");
    $finish;
  end

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  function automatic element_t nextRandom();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return element_t'(lcgState >> 16);              // Upper bits are the better ones
  endfunction

  task automatic compareElement(input string testName, input element_t expected,
                                input element_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      testErrors++;
      $display("Mismatch in %s: expected value %h, actual %h", testName, expected, actual);
    end
  endtask

  task automatic compareError(input string testName, input heapError_t expected,
                              input heapError_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      testErrors++;
      $display("Mismatch in %s: expected error %s, actual %s", testName,
               expected.name(), actual.name());
    end
  endtask

  // One command on a falling edge, then wait for its reply
  task automatic issue(input heapAction_t action, input arrayId_t array,
                       input elementIndex_t index, input element_t data);
    int waited;
    @(negedge clock);
    command.action = action;
    command.array  = array;
    command.index  = index;
    command.data   = data;
    waited = 0;
    do begin
      @(negedge clock);                             // Outputs settled after the edge
      waited++;
    end while (!respValid && waited < REPLY_WAIT);
    command   = '0;                                 // Back to idle
    lastReply = response;
    if (!respValid) begin
      errors++;
      testErrors++;
      $display("No reply to %s on array %0d within %0d cycles", action.name(), array,
               REPLY_WAIT);
    end
  endtask

  task automatic expectValue(input string testName, input heapAction_t action,
                             input arrayId_t array, input elementIndex_t index,
                             input element_t data, input element_t expected);
    issue(action, array, index, data);
    compareError(testName, errNone, lastReply.error);
    compareElement(testName, expected, lastReply.value);
  endtask

  task automatic expectFault(input string testName, input heapAction_t action,
                             input arrayId_t array, input elementIndex_t index,
                             input element_t data, input heapError_t expected);
    issue(action, array, index, data);
    compareError(testName, expected, lastReply.error);
  endtask

  task automatic reportTest(input string testName);
    $display("%s: finished with %0d errors", testName, testErrors);
    testErrors = 0;
  endtask

  // --------------------------------------------------
  // Tests
  // --------------------------------------------------
  task automatic testAfterReset();
    string name = "access after reset";
    expectFault(name, actRead, 2'd0, 2'd0, '0, errNotAllocated);
    expectFault(name, actWrite, 2'd0, 2'd1, 12'h123, errNotAllocated);
    compareElement(name, '0, lastReply.value);      // Reset value still held
    reportTest(name);
  endtask

  task automatic testAllocation();
    string name = "allocation";
    for (int i = 0; i < ARRAYS; i++)
      expectValue(name, actAlloc, '0, '0, '0, element_t'(i));  // Fresh slots in order
    expectFault(name, actAlloc, '0, '0, '0, errOutOfMemory);
    expectFault(name, actAlloc, '0, '0, '0, errOutOfMemory);  // Still none without a Free
    compareElement(name, element_t'(ARRAYS - 1), lastReply.value);
    reportTest(name);
  endtask

  task automatic testWriteRead();
    string    name = "write and read";
    element_t values [3];
    for (int i = 0; i < 3; i++)
      values[i] = nextRandom();
    expectValue(name, actWrite, 2'd0, 2'd2, values[2], values[2]);
    expectValue(name, actSize, 2'd0, '0, '0, element_t'(3));  // Grown past index 2
    expectValue(name, actWrite, 2'd0, 2'd0, values[0], values[0]);
    expectValue(name, actWrite, 2'd0, 2'd1, values[1], values[1]);
    expectValue(name, actSize, 2'd0, '0, '0, element_t'(3));  // No growth inside
    for (int i = 0; i < 3; i++)
      expectValue(name, actRead, 2'd0, elementIndex_t'(i), '0, values[i]);
    expectFault(name, actRead, 2'd0, 2'd3, '0, errOutOfBounds);
    reportTest(name);
  endtask

  task automatic testPushPop();
    string    name = "push and pop";
    element_t pushed [ARRAY_LENGTH];
    for (int i = 0; i < ARRAY_LENGTH; i++) begin
      pushed[i] = nextRandom();
      expectValue(name, actPush, 2'd1, '0, pushed[i], pushed[i]);
    end
    expectValue(name, actSize, 2'd1, '0, '0, element_t'(ARRAY_LENGTH));
    expectFault(name, actPush, 2'd1, '0, nextRandom(), errFull);
    for (int i = ARRAY_LENGTH - 1; i >= 0; i--)
      expectValue(name, actPop, 2'd1, '0, '0, pushed[i]);  // Last in, first out
    expectFault(name, actPop, 2'd1, '0, '0, errEmpty);
    reportTest(name);
  endtask

  task automatic testAdd();
    string    name = "add in place";
    element_t base;
    element_t addend;
    element_t total;
    base   = nextRandom();
    addend = nextRandom();
    total  = element_t'((32'(base) + 32'(addend)) % (1 << DATA_BITS));
    expectValue(name, actWrite, 2'd2, 2'd0, base, base);
    expectValue(name, actAdd, 2'd2, 2'd0, addend, total);
    expectValue(name, actRead, 2'd2, 2'd0, '0, total);
    expectValue(name, actWrite, 2'd2, 2'd1, 12'hFF0, 12'hFF0);
    expectValue(name, actAdd, 2'd2, 2'd1, 12'h025, 12'h015);  // Carry out dropped
    expectValue(name, actRead, 2'd2, 2'd1, '0, 12'h015);
    expectFault(name, actAdd, 2'd2, 2'd2, 12'h001, errOutOfBounds);
    reportTest(name);
  endtask

  task automatic testFree();
    string name = "free and reuse";
    expectValue(name, actFree, 2'd3, '0, '0, element_t'(3));
    expectFault(name, actWrite, 2'd3, 2'd0, 12'h0AA, errFreed);
    expectFault(name, actRead, 2'd3, 2'd0, '0, errFreed);
    expectFault(name, actFree, 2'd3, '0, '0, errFreed);
    expectValue(name, actFree, 2'd2, '0, '0, element_t'(2));
    expectValue(name, actAlloc, '0, '0, '0, element_t'(2));  // Newest freed first
    expectValue(name, actSize, 2'd2, '0, '0, element_t'(0));
    expectValue(name, actAlloc, '0, '0, '0, element_t'(3));
    reportTest(name);
  endtask

  // --------------------------------------------------
  // Sequence
  // --------------------------------------------------
  initial begin
    reset      = 1'b0;
    command    = '0;
    lastReply  = '0;
    lcgState   = 13;
    checks     = 0;
    errors     = 0;
    testErrors = 0;
    repeat (4) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;

    testAfterReset();
    testAllocation();
    testWriteRead();
    testPushPop();
    testAdd();
    testFree();

    @(negedge clock);
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// ==== arrayHeap.f ====
source/heapPkg.sv
source/heapBookkeeper.sv
source/elementStore.sv
source/heapResponder.sv
source/arrayHeap.sv
testbench/arrayHeap_properties.sv
testbench/arrayHeapTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the array heap testbench with Verilator, run it, and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module arrayHeapTb -f arrayHeap.f \
  --Mdir build -o arrayHeapSim

./build/arrayHeapSim | tee sim.log

if grep -q "Test completed successfully" sim.log; then
  exit 0
else
  exit 1
fi
